//--- Makefile
# Verilator build of the cache testbench
SIM = obj_dir/Vcache_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module cache_tb -f cache.f

# the log decides pass or fail
run: compile
	$(SIM) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cache.f
source/cache_pkg.sv
source/cache_way.sv
source/way_select.sv
source/cache_ctrl.sv
source/cache_top.sv
test/ddr_model.sv
test/cache_tb.sv

//--- source/cache_ctrl.sv
// ############################
// one request in flight, rd_en/wr_en taken in idle only
// ############################
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  cache_addr_u          rd_addr,
    input  logic                 rd_en,
    input  cache_addr_u          wr_addr,
    input  word_t                wr_data,
    input  logic                 wr_en,
    output logic                 rd_fin,
    output word_t                rd_data,
    output logic                 wr_fin,
    output cache_addr_u          ddr_rd_addr,
    output logic                 ddr_rd_en,
    output cache_addr_u          ddr_wr_addr,
    output line_t                ddr_wr_data,
    output logic                 ddr_wr_en,
    input  logic                 ddr_rd_fin,
    input  line_t                ddr_rd_data,
    input  logic                 ddr_wr_fin,
    output logic [index_len-1:0] index,
    output way_wr_t              way_wr [num_ways],
    output logic [tag_len-1:0]   req_tag,
    input  logic                 hit,
    input  way_vec_t             hit_way,
    input  line_t                hit_line,
    input  way_vec_t             victim,
    input  logic                 all_used
);

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_rd_wait,      // read miss, line fetch
        st_wr_hit_wait,
        st_wm_rd_wait,   // write miss, line fetch
        st_wm_wr_wait,   // write miss, merged line out
        st_done
    } state_t;

    typedef struct packed {
        logic        is_wr;
        cache_addr_u addr;
        word_t       data;
    } req_t;

    localparam way_status_t st_live = '{used: 1'b1, valid: 1'b1};

    state_t      state;
    req_t        req;
    way_vec_t    victim_q;
    cache_addr_u line_addr;
    line_t       merged_hit;
    line_t       merged_miss;

    function automatic way_wr_t fill_cmd(logic [tag_len-1:0] tag, line_t data);
        return '{status_en: 1'b1, data_en: 1'b1, tag: tag, status: st_live, data: data};
    endfunction

    // incoming index at request time, held index after
    always_comb begin
        if (state == st_idle) begin
            index = wr_en ? wr_addr.f.index : rd_addr.f.index;
        end else begin
            index = req.addr.f.index;
        end
    end

    assign req_tag = req.addr.f.tag;

    always_comb begin
        line_addr.f = '{tag: req.addr.f.tag, index: req.addr.f.index, offset: '0};
    end

    assign merged_hit  = word_insert(hit_line, req.addr.f.offset, req.data);
    assign merged_miss = word_insert(ddr_rd_data, req.addr.f.offset, req.data);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= st_idle;
            rd_fin    <= 1'b0;
            rd_data   <= '0;
            wr_fin    <= 1'b0;
            ddr_rd_en <= 1'b0;
            ddr_wr_en <= 1'b0;
            way_wr    <= '{default: '0};
        end else begin
            rd_fin    <= 1'b0;
            wr_fin    <= 1'b0;
            ddr_rd_en <= 1'b0;
            ddr_wr_en <= 1'b0;
            way_wr    <= '{default: '0}; // way commands last one cycle
            case (state)
                st_idle: begin
                    if (rd_en || wr_en) begin
                        state <= st_compare;
                    end
                end
                st_compare: begin
                    for (int i = 0; i < num_ways; i++) begin
                        // aging on reads, used implies valid so valid stays 1
                        if (!req.is_wr && (all_used || hit_way[i])) begin
                            way_wr[i].status_en <= 1'b1;
                            way_wr[i].status    <= '{used: hit_way[i], valid: 1'b1};
                        end
                        if (req.is_wr && hit_way[i]) begin
                            way_wr[i] <= fill_cmd(req.addr.f.tag, merged_hit);
                        end
                    end
                    if (!req.is_wr && hit) begin
                        rd_fin  <= 1'b1;
                        rd_data <= word_extract(hit_line, req.addr.f.offset);
                        state   <= st_done;
                    end else if (!req.is_wr) begin
                        ddr_rd_en <= 1'b1;
                        state     <= st_rd_wait;
                    end else if (hit) begin
                        ddr_wr_en <= 1'b1;
                        state     <= st_wr_hit_wait;
                    end else begin
                        ddr_rd_en <= 1'b1;
                        state     <= st_wm_rd_wait;
                    end
                end
                st_rd_wait: begin
                    if (ddr_rd_fin) begin
                        for (int i = 0; i < num_ways; i++) begin
                            if (victim_q[i]) begin
                                way_wr[i] <= fill_cmd(req.addr.f.tag, ddr_rd_data);
                            end
                        end
                        rd_fin  <= 1'b1;
                        rd_data <= word_extract(ddr_rd_data, req.addr.f.offset);
                        state   <= st_done;
                    end
                end
                st_wm_rd_wait: begin
                    if (ddr_rd_fin) begin
                        for (int i = 0; i < num_ways; i++) begin
                            if (victim_q[i]) begin
                                way_wr[i] <= fill_cmd(req.addr.f.tag, merged_miss);
                            end
                        end
                        ddr_wr_en <= 1'b1;
                        state     <= st_wm_wr_wait;
                    end
                end
                st_wr_hit_wait, st_wm_wr_wait: begin
                    if (ddr_wr_fin) begin
                        wr_fin <= 1'b1;
                        state  <= st_done;
                    end
                end
                default: state <= st_idle; // st_done, last way write goes out here
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && (rd_en || wr_en)) begin
            req <= '{is_wr: wr_en, addr: wr_en ? wr_addr : rd_addr, data: wr_data};
        end
        if (state == st_compare) begin
            victim_q    <= victim;
            ddr_rd_addr <= line_addr;
            ddr_wr_addr <= line_addr;
            ddr_wr_data <= merged_hit;
        end
        if (state == st_wm_rd_wait && ddr_rd_fin) begin
            ddr_wr_data <= merged_miss;
        end
    end

    a_req_in_idle: assert property (@(posedge clk) disable iff (!rstn)
        (rd_en || wr_en) |-> state == st_idle);

    a_req_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(rd_en && wr_en));

endmodule

//--- source/cache_pkg.sv
// ############################
// address field widths are fixed here, word index is offset[3:2]
// ############################

package cache_pkg;

    localparam int addr_len = 27;
    localparam int offset_len = 4;
    localparam int index_len = 6;
    localparam int tag_len = addr_len - index_len - offset_len;
    localparam int word_len = 32;
    localparam int line_len = 128;
    localparam int words_per_line = line_len / word_len;
    localparam int num_ways = 4;
    localparam int word_sel_len = $clog2(words_per_line);

    typedef logic [word_len-1:0] word_t;
    typedef logic [line_len-1:0] line_t; // word 0 in the low bits

    typedef struct packed {
        logic [tag_len-1:0]    tag;
        logic [index_len-1:0]  index;
        logic [offset_len-1:0] offset; // byte offset in the line
    } cache_addr_t;

    typedef union packed {
        logic [addr_len-1:0] raw;
        cache_addr_t         f;
    } cache_addr_u;

    typedef struct packed {
        logic used;
        logic valid;
    } way_status_t;

    typedef logic [num_ways-1:0] way_vec_t;

    typedef struct packed {
        logic [tag_len-1:0] tag;
        way_status_t        status;
        line_t              data;
    } way_rd_t;

    typedef struct packed {
        logic               status_en;
        logic               data_en;  // also loads the tag
        logic [tag_len-1:0] tag;
        way_status_t        status;
        line_t              data;
    } way_wr_t;

    function automatic word_t word_extract(line_t line, logic [offset_len-1:0] offset);
        logic [word_sel_len-1:0] sel;
        sel = offset[offset_len-1 -: word_sel_len];
        return line[sel*word_len +: word_len];
    endfunction

    function automatic line_t word_insert(line_t line, logic [offset_len-1:0] offset,
                                          word_t word);
        logic [word_sel_len-1:0] sel;
        line_t                   res;
        sel = offset[offset_len-1 -: word_sel_len];
        res = line;
        res[sel*word_len +: word_len] = word;
        return res;
    endfunction

endpackage

//--- source/cache_top.sv
// ############################
// 4 ways x 64 sets of 128-bit lines, write-through
// ############################
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  cache_addr_u rd_addr,
    input  logic        rd_en,
    input  cache_addr_u wr_addr,
    input  word_t       wr_data,
    input  logic        wr_en,
    output logic        rd_fin,
    output word_t       rd_data,
    output logic        wr_fin,
    output cache_addr_u ddr_rd_addr,
    output logic        ddr_rd_en,
    output cache_addr_u ddr_wr_addr,
    output line_t       ddr_wr_data,
    output logic        ddr_wr_en,
    input  logic        ddr_rd_fin,
    input  line_t       ddr_rd_data,
    input  logic        ddr_wr_fin
);

    logic [index_len-1:0] index;
    logic [tag_len-1:0]   req_tag;
    way_wr_t              way_wr [num_ways];
    way_rd_t              way_rd [num_ways];
    logic                 hit;
    logic                 all_used;
    way_vec_t             hit_way;
    way_vec_t             victim;
    line_t                hit_line;

    cache_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_en       (wr_en),
        .rd_fin      (rd_fin),
        .rd_data     (rd_data),
        .wr_fin      (wr_fin),
        .ddr_rd_addr (ddr_rd_addr),
        .ddr_rd_en   (ddr_rd_en),
        .ddr_wr_addr (ddr_wr_addr),
        .ddr_wr_data (ddr_wr_data),
        .ddr_wr_en   (ddr_wr_en),
        .ddr_rd_fin  (ddr_rd_fin),
        .ddr_rd_data (ddr_rd_data),
        .ddr_wr_fin  (ddr_wr_fin),
        .index       (index),
        .way_wr      (way_wr),
        .req_tag     (req_tag),
        .hit         (hit),
        .hit_way     (hit_way),
        .hit_line    (hit_line),
        .victim      (victim),
        .all_used    (all_used)
    );

    way_select u_sel (
        .ways     (way_rd),
        .req_tag  (req_tag),
        .hit      (hit),
        .hit_way  (hit_way),
        .hit_line (hit_line),
        .victim   (victim),
        .all_used (all_used)
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        cache_way u_way (
            .clk   (clk),
            .rstn  (rstn),
            .index (index),
            .wr    (way_wr[w]),
            .rd    (way_rd[w])
        );
    end

endmodule

//--- source/cache_way.sv
// ############################
// read data appears one cycle after index, old contents on a same-set write
// ############################
`timescale 1ns/1ps

module cache_way
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [index_len-1:0] index,
    input  way_wr_t              wr,
    output way_rd_t              rd
);

    localparam int num_sets = 2 ** index_len;

    way_status_t        status_mem [num_sets];
    logic [tag_len-1:0] tag_mem [num_sets];
    line_t              data_mem [num_sets];

    // all sets invalid and unused after reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < num_sets; i++) begin
                status_mem[i] <= '0;
            end
        end else if (wr.status_en) begin
            status_mem[index] <= wr.status;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.data_en) begin
            tag_mem[index]  <= wr.tag; // tag only changes with a new line
            data_mem[index] <= wr.data;
        end
        rd <= '{tag: tag_mem[index], status: status_mem[index], data: data_mem[index]};
    end

    // a line written without status would stay invalid
    a_data_with_status: assert property (@(posedge clk) disable iff (!rstn)
        $rose(wr.data_en) |-> wr.status_en);

endmodule

//--- source/way_select.sv
// ############################
// purely combinational, inputs come straight from the way registers
// ############################
`timescale 1ns/1ps

module way_select
    import cache_pkg::*;
(
    input  way_rd_t            ways [num_ways],
    input  logic [tag_len-1:0] req_tag,
    output logic               hit,
    output way_vec_t           hit_way,
    output line_t              hit_line,
    output way_vec_t           victim,
    output logic               all_used
);

    way_vec_t match;
    way_vec_t used;

    always_comb begin
        for (int i = 0; i < num_ways; i++) begin
            match[i] = ways[i].status.valid && (ways[i].tag == req_tag);
            used[i]  = ways[i].status.used;
        end
    end

    // lowest matching way wins
    always_comb begin
        hit_way = '0;
        for (int i = num_ways - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_way    = '0;
                hit_way[i] = 1'b1;
            end
        end
    end

    assign hit = |match;

    always_comb begin
        hit_line = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (hit_way[i]) begin
                hit_line = hit_line | ways[i].data;
            end
        end
    end

    assign all_used = &used;

    // highest way with a clear used bit, way 3 when none is clear
    always_comb begin
        victim = '0;
        victim[num_ways-1] = 1'b1;
        for (int i = 0; i < num_ways; i++) begin
            if (!used[i]) begin
                victim    = '0;
                victim[i] = 1'b1;
            end
        end
    end

    // fills go only to missing tags, so a set never holds a tag twice
    always_comb begin
        a_one_match: assert ($onehot0(match))
            else $error("tag %h found in more than one way", req_tag);
    end

endmodule

//--- test/cache_tb.sv
// ############################
// one request at a time, the next one a cycle after its fin
// hit or miss is only checked where the sequence makes it certain
// ############################
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam int period = 20;
    localparam int reset_cycles = 16;
    localparam int num_directed = 17;
    localparam int num_random = 300;
    localparam int any_outcome = 0;
    localparam int want_hit = 1;
    localparam int want_miss = 2;

    logic        clk = 1'b0;
    logic        rstn;
    cache_addr_u rd_addr;
    logic        rd_en;
    cache_addr_u wr_addr;
    word_t       wr_data;
    logic        wr_en;
    logic        rd_fin;
    word_t       rd_data;
    logic        wr_fin;
    cache_addr_u ddr_rd_addr;
    logic        ddr_rd_en;
    cache_addr_u ddr_wr_addr;
    line_t       ddr_wr_data;
    logic        ddr_wr_en;
    logic        ddr_rd_fin;
    line_t       ddr_rd_data;
    logic        ddr_wr_fin;

    word_t               sb [logic [addr_len-3:0]]; // keyed by word address
    word_t               exp_word;
    line_t               exp_line;
    logic [addr_len-1:0] exp_line_addr;
    logic                cur_is_wr = 1'b0;
    int                  cur_mode = any_outcome;
    int                  errors = 0;
    int                  requests = 0;
    int                  cyc = 0;
    int                  age = 0;     // cycles since the last request strobe
    logic                saw_rd = 1'b0;
    logic                saw_wr = 1'b0;
    logic                rst_q = 1'b0;
    logic                rst_q2 = 1'b0;
    integer              seed = 32'h0fc7_6fc9;

    // port names match, so both connect by name
    cache_top dut (.*);
    ddr_model u_ddr (.*);

    always #(period / 2) clk = ~clk;

    function automatic word_t word_at(logic [addr_len-3:0] waddr);
        if (sb.exists(waddr)) begin
            return sb[waddr];
        end
        return word_t'(waddr); // untouched memory holds its own word address
    endfunction

    function automatic line_t line_image(logic [addr_len-1:0] addr);
        line_t line;
        for (int w = 0; w < words_per_line; w++) begin
            line[w*word_len +: word_len] = word_at({addr[addr_len-1:offset_len], 2'(w)});
        end
        return line;
    endfunction

    function automatic logic [addr_len-1:0] make_addr(logic [tag_len-1:0] tag,
                                                      logic [index_len-1:0] index,
                                                      logic [1:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    task automatic note_error(input string msg);
        errors++;
        $display("%s (at %0t ns)", msg, $time);
    endtask

    task automatic end_run(input bit timed_out);
        $display("requests %0d, errors %0d", requests, errors);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic wait_fin(input logic is_wr);
        while (!(is_wr ? wr_fin : rd_fin)) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk); // controller passes through done before idle
        #1;
    endtask

    task automatic read_word(input logic [addr_len-1:0] addr, input int mode);
        exp_word      = word_at(addr[addr_len-1:2]);
        exp_line_addr = {addr[addr_len-1:offset_len], {offset_len{1'b0}}};
        cur_is_wr     = 1'b0;
        cur_mode      = mode;
        requests++;
        rd_addr.raw   = addr;
        rd_en         = 1'b1;
        @(posedge clk);
        #1;
        rd_en = 1'b0;
        wait_fin(1'b0);
    endtask

    task automatic write_word(input logic [addr_len-1:0] addr, input word_t data,
                              input int mode);
        sb[addr[addr_len-1:2]] = data; // write-through, memory follows at once
        exp_line      = line_image(addr);
        exp_line_addr = {addr[addr_len-1:offset_len], {offset_len{1'b0}}};
        cur_is_wr     = 1'b1;
        cur_mode      = mode;
        requests++;
        wr_addr.raw   = addr;
        wr_data       = data;
        wr_en         = 1'b1;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        wait_fin(1'b1);
    endtask

    always @(posedge clk) begin
        cyc    <= cyc + 1;
        rst_q  <= rstn;
        rst_q2 <= rst_q;
        if (!(rstn && rst_q2)) begin
            if (cyc > 0) begin
                assert (!rd_fin && !wr_fin && !ddr_rd_en && !ddr_wr_en)
                    else note_error("a fin or DDR strobe is high during or just after reset");
            end
        end else begin
            if (rd_en || wr_en) begin
                age    = 0;
                saw_rd = 1'b0;
                saw_wr = 1'b0;
            end else begin
                age = age + 1;
            end
            if (ddr_rd_en) begin
                saw_rd = 1'b1;
                assert (ddr_rd_addr.raw == exp_line_addr)
                    else note_error($sformatf("mismatch ddr_rd_addr: got %h, expected %h",
                                              ddr_rd_addr.raw, exp_line_addr));
                assert (cur_mode != want_hit)
                    else note_error("DDR fetch issued for a request that should hit");
            end
            if (ddr_wr_en) begin
                saw_wr = 1'b1;
                assert (cur_is_wr) else note_error("DDR write issued during a read");
                assert (ddr_wr_addr.raw == exp_line_addr)
                    else note_error($sformatf("mismatch ddr_wr_addr: got %h, expected %h",
                                              ddr_wr_addr.raw, exp_line_addr));
                assert (ddr_wr_data == exp_line)
                    else note_error($sformatf("mismatch ddr_wr_data: got %h, expected %h",
                                              ddr_wr_data, exp_line));
                if (cur_mode == want_hit) begin
                    assert (age == 2)
                        else note_error($sformatf("mismatch ddr_wr_en delay: got %h, expected %h",
                                                  age, 2));
                end
                if (cur_mode == want_miss) begin
                    assert (saw_rd) else note_error("write miss went to DDR before the line fetch");
                end
            end
            if (rd_fin) begin
                assert (!cur_is_wr) else note_error("rd_fin pulsed during a write");
                assert (rd_data == exp_word)
                    else note_error($sformatf("mismatch rd_data: got %h, expected %h",
                                              rd_data, exp_word));
                if (cur_mode == want_hit) begin
                    assert (age == 2)
                        else note_error($sformatf("mismatch rd_fin delay: got %h, expected %h",
                                                  age, 2));
                end
                if (cur_mode == want_miss) begin
                    assert (saw_rd) else note_error("read miss finished without a line fetch");
                end
            end
            if (wr_fin) begin
                assert (cur_is_wr) else note_error("wr_fin pulsed during a read");
                assert (saw_wr) else note_error("wr_fin came before any DDR write");
            end
        end
    end

    // generous bound per request, a hang ends here
    initial begin
        #(period * (reset_cycles + 200 * (num_directed + num_random)));
        $display("watchdog expired before all requests completed");
        end_run(1'b1);
    end

    initial begin
        logic [31:0]         r;
        word_t               data;
        logic [addr_len-1:0] addr;
        rstn    = 1'b0;
        rd_addr = '0;
        rd_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_en   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rstn = 1'b1;
        repeat (2) @(posedge clk);
        #1;

        // miss, then hits on the same line
        read_word(make_addr(17'h00123, 6'd3, 2'd1), want_miss);
        read_word(make_addr(17'h00123, 6'd3, 2'd1), want_hit);
        read_word(make_addr(17'h00123, 6'd3, 2'd2), want_hit);
        write_word(make_addr(17'h00123, 6'd3, 2'd2), 32'hcafe_0001, want_hit);
        read_word(make_addr(17'h00123, 6'd3, 2'd2), want_hit);

        // write miss allocates the merged line
        write_word(make_addr(17'h1beef, 6'd9, 2'd3), 32'h5a5a_1234, want_miss);
        read_word(make_addr(17'h1beef, 6'd9, 2'd3), want_hit);
        read_word(make_addr(17'h1beef, 6'd9, 2'd0), want_hit);

        // four tags fill set 20, a fifth one must be fetched
        for (int t = 0; t < 4; t++) begin
            read_word(make_addr(tag_len'(17'h00400 + t), 6'd20, 2'd0), want_miss);
        end
        for (int t = 0; t < 4; t++) begin
            read_word(make_addr(tag_len'(17'h00400 + t), 6'd20, 2'd0), want_hit);
        end
        read_word(make_addr(17'h00404, 6'd20, 2'd0), want_miss);

        // eight tags over sets 3 and 9
        for (int n = 0; n < num_random; n++) begin
            r    = $random(seed);
            data = $random(seed);
            addr = make_addr({14'h2a5c, r[2:0]}, r[3] ? 6'd3 : 6'd9, r[5:4]);
            if (r[6]) begin
                write_word(addr, data, any_outcome);
            end else begin
                read_word(addr, any_outcome);
            end
        end
        end_run(1'b0);
    end

endmodule

//--- test/ddr_model.sv
// ############################
// untouched lines read as word address plus word number
// answers 1 to 6 cycles after a strobe, one read and one write at a time
// ############################
`timescale 1ns/1ps

module ddr_model
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  cache_addr_u ddr_rd_addr,
    input  logic        ddr_rd_en,
    input  cache_addr_u ddr_wr_addr,
    input  line_t       ddr_wr_data,
    input  logic        ddr_wr_en,
    output logic        ddr_rd_fin,
    output line_t       ddr_rd_data,
    output logic        ddr_wr_fin
);

    line_t  mem [logic [addr_len-1:0]]; // only written lines are stored
    integer seed = 32'h0fc7_6fc9;

    function automatic line_t line_at(logic [addr_len-1:0] addr);
        line_t line;
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        for (int w = 0; w < words_per_line; w++) begin
            line[w*word_len +: word_len] = word_t'(addr[addr_len-1:2]) + word_t'(w);
        end
        return line;
    endfunction

    initial begin
        int                  lat;
        logic [addr_len-1:0] addr;
        ddr_rd_fin  = 1'b0;
        ddr_rd_data = '0;
        forever begin
            @(posedge clk);
            if (rstn && ddr_rd_en) begin
                addr = ddr_rd_addr.raw;
                lat  = 1 + ($unsigned($random(seed)) % 6);
                repeat (lat - 1) @(posedge clk);
                #1;
                ddr_rd_data = line_at(addr);
                ddr_rd_fin  = 1'b1;
                @(posedge clk);
                #1;
                ddr_rd_fin  = 1'b0;
            end
        end
    end

    initial begin
        int lat;
        ddr_wr_fin = 1'b0;
        forever begin
            @(posedge clk);
            if (rstn && ddr_wr_en) begin
                mem[ddr_wr_addr.raw] = ddr_wr_data; // data valid with the strobe
                lat = 1 + ($unsigned($random(seed)) % 6);
                repeat (lat - 1) @(posedge clk);
                #1;
                ddr_wr_fin = 1'b1;
                @(posedge clk);
                #1;
                ddr_wr_fin = 1'b0;
            end
        end
    end

endmodule
